//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_controller
FILELIST  ?= files.f

SRCS := $(shell grep -v '^+' $(FILELIST))
OBJ  := obj_dir
BIN  := $(OBJ)/V$(TOP)
LOG  := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST) tb/controller_trace.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

//--- files.f
rtl/ctrl_pkg.sv
rtl/ctrl_if.sv
rtl/fetch_decode.sv
rtl/alu_decode.sv
rtl/branch_decode.sv
rtl/control_register.sv
rtl/controller.sv
tb/controller_sva.sv
tb/controller_checker.sv
tb/tb_controller.sv

//--- rtl/alu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module alu_decode (
        input  ctrl_pkg::beat_t  timer,
        input  ctrl_pkg::instr_u instruction,
        ctrl_if.drive            cw
);
        import ctrl_pkg::*;

        logic [7:0]             op;
        logic [alu_entry_w-1:0] entry;

        assign op = instruction.reg_form.opcode;

        always_comb begin
                entry = '0;
                if (op <= op_rev) begin
                        entry = alu_table[op[4:0]];
                end
        end

        always_comb begin
                cw.hit      = (timer == beat_exec) && (op <= op_rev);
                cw.dest_reg = instruction.reg_form.dest;
                cw.sour_reg = instruction.reg_form.sour;
                cw.offset   = '0;
                cw.rec      = rec_none;
                {cw.alu_func, cw.sst, cw.sci, cw.alu_in_sel} = entry;
                cw.en_reg   = !((op == op_cmp) || (op == op_test));     // flags only
                cw.en_pc    = 1'b0;
        end

endmodule

`default_nettype wire

//--- rtl/branch_decode.sv
`timescale 1ns/1ps
`default_nettype none

module branch_decode (
        input  ctrl_pkg::beat_t  timer,
        input  ctrl_pkg::instr_u instruction,
        input  logic             c,
        input  logic             z,
        input  logic             s,
        ctrl_if.drive            cw
);
        import ctrl_pkg::*;

        logic [7:0] op;

        assign op = instruction.jump_form.opcode;

        always_comb begin
                cw.hit        = 1'b0;
                cw.dest_reg   = '0;
                cw.sour_reg   = '0;
                cw.offset     = instruction.jump_form.offset;
                cw.sst        = sst_keep;
                cw.sci        = sci_zero;
                cw.rec        = rec_none;
                cw.alu_func   = fn_pass;
                cw.alu_in_sel = in_offset;     // pc + offset
                cw.en_reg     = 1'b0;
                cw.en_pc      = 1'b0;
                if (timer == beat_exec) begin
                        cw.hit = 1'b1;
                        case (op)
                                op_jmp: cw.en_pc = 1'b1;
                                op_js:  cw.en_pc = s;
                                op_jns: cw.en_pc = ~s;
                                op_jc:  cw.en_pc = c;
                                op_jnc: cw.en_pc = ~c;
                                op_jz:  cw.en_pc = z;
                                op_jnz: cw.en_pc = ~z;
                                op_stc: begin
                                        cw.sst        = sst_set;
                                        cw.alu_in_sel = in_reg;
                                end
                                op_clc: begin
                                        cw.sst        = sst_clear;
                                        cw.alu_in_sel = in_reg;
                                end
                                default: cw.hit = 1'b0;     // not ours
                        endcase
                end
        end

endmodule

`default_nettype wire

//--- rtl/control_register.sv
`timescale 1ns/1ps
`default_nettype none

module control_register (
        input  logic                                 clk,
        input  logic                                 arst_n,
        ctrl_if.take                                 fetch_cw,
        ctrl_if.take                                 alu_cw,
        ctrl_if.take                                 branch_cw,
        output logic [ctrl_pkg::reg_addr_w-1:0]      dest_reg,
        output logic [ctrl_pkg::reg_addr_w-1:0]      sour_reg,
        output logic [ctrl_pkg::offset_w-1:0]        offset,
        output logic [ctrl_pkg::code_w-1:0]          sst,
        output logic [ctrl_pkg::code_w-1:0]          sci,
        output logic [ctrl_pkg::code_w-1:0]          rec,
        output logic [ctrl_pkg::alu_func_w-1:0]      alu_func,
        output logic [ctrl_pkg::alu_in_sel_w-1:0]    alu_in_sel,
        output logic                                 en_reg,
        output logic                                 en_pc
);
        import ctrl_pkg::*;

        localparam int cw_w = 2 * reg_addr_w + offset_w + 3 * code_w + alu_func_w
                              + alu_in_sel_w + 2;

        logic [cw_w-1:0] fetch_word;
        logic [cw_w-1:0] alu_word;
        logic [cw_w-1:0] branch_word;
        logic [cw_w-1:0] next_word;
        logic            any_hit;

        assign fetch_word = {fetch_cw.dest_reg, fetch_cw.sour_reg, fetch_cw.offset,
                             fetch_cw.sst, fetch_cw.sci, fetch_cw.rec, fetch_cw.alu_func,
                             fetch_cw.alu_in_sel, fetch_cw.en_reg, fetch_cw.en_pc};
        assign alu_word = {alu_cw.dest_reg, alu_cw.sour_reg, alu_cw.offset,
                           alu_cw.sst, alu_cw.sci, alu_cw.rec, alu_cw.alu_func,
                           alu_cw.alu_in_sel, alu_cw.en_reg, alu_cw.en_pc};
        assign branch_word = {branch_cw.dest_reg, branch_cw.sour_reg, branch_cw.offset,
                              branch_cw.sst, branch_cw.sci, branch_cw.rec, branch_cw.alu_func,
                              branch_cw.alu_in_sel, branch_cw.en_reg, branch_cw.en_pc};

        assign any_hit = fetch_cw.hit | alu_cw.hit | branch_cw.hit;

        always_comb begin
                next_word = fetch_word;     // decoders are disjoint
                if (alu_cw.hit) begin
                        next_word = alu_word;
                end else if (branch_cw.hit) begin
                        next_word = branch_word;
                end
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        dest_reg   <= '0;
                        sour_reg   <= '0;
                        offset     <= '0;
                        sst        <= sst_keep;
                        sci        <= sci_zero;
                        rec        <= rec_none;
                        alu_func   <= fn_pass;
                        alu_in_sel <= in_reg;
                        en_reg     <= 1'b0;
                        en_pc      <= 1'b0;
                end else if (any_hit) begin     // unknown beat/opcode holds
                        {dest_reg, sour_reg, offset, sst, sci, rec, alu_func,
                         alu_in_sel, en_reg, en_pc} <= next_word;
                end
        end

endmodule

`default_nettype wire

//--- rtl/controller.sv
`timescale 1ns/1ps
`default_nettype none

module controller (
        input  logic                              clk,
        input  logic                              arst_n,
        input  logic [2:0]                        timer,
        input  logic [15:0]                       instruction,
        input  logic                              c,
        input  logic                              z,
        input  logic                              s,
        output logic [ctrl_pkg::reg_addr_w-1:0]   dest_reg,
        output logic [ctrl_pkg::reg_addr_w-1:0]   sour_reg,
        output logic [ctrl_pkg::offset_w-1:0]     offset,
        output logic [ctrl_pkg::code_w-1:0]       sst,
        output logic [ctrl_pkg::code_w-1:0]       sci,
        output logic [ctrl_pkg::code_w-1:0]       rec,
        output logic [ctrl_pkg::alu_func_w-1:0]   alu_func,
        output logic [ctrl_pkg::alu_in_sel_w-1:0] alu_in_sel,
        output logic                              en_reg,
        output logic                              en_pc
);
        import ctrl_pkg::*;

        beat_t  beat;
        instr_u instr;

        assign beat  = beat_t'(timer);     // 010, 101, 110, 111 fall through
        assign instr = instruction;

        ctrl_if fetch_cw ();
        ctrl_if alu_cw ();
        ctrl_if branch_cw ();

        fetch_decode fetch_decode_inst (
                .timer (beat),
                .cw    (fetch_cw)
        );

        alu_decode alu_decode_inst (
                .timer       (beat),
                .instruction (instr),
                .cw          (alu_cw)
        );

        branch_decode branch_decode_inst (
                .timer       (beat),
                .instruction (instr),
                .c           (c),
                .z           (z),
                .s           (s),
                .cw          (branch_cw)
        );

        control_register control_register_inst (
                .clk        (clk),
                .arst_n     (arst_n),
                .fetch_cw   (fetch_cw),
                .alu_cw     (alu_cw),
                .branch_cw  (branch_cw),
                .dest_reg   (dest_reg),
                .sour_reg   (sour_reg),
                .offset     (offset),
                .sst        (sst),
                .sci        (sci),
                .rec        (rec),
                .alu_func   (alu_func),
                .alu_in_sel (alu_in_sel),
                .en_reg     (en_reg),
                .en_pc      (en_pc)
        );

endmodule

`default_nettype wire

//--- rtl/ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;
        import ctrl_pkg::*;

        logic                    hit;     // decoder owns this beat/opcode
        logic [reg_addr_w-1:0]   dest_reg;
        logic [reg_addr_w-1:0]   sour_reg;
        logic [offset_w-1:0]     offset;
        logic [code_w-1:0]       sst;
        logic [code_w-1:0]       sci;
        logic [code_w-1:0]       rec;
        logic [alu_func_w-1:0]   alu_func;
        logic [alu_in_sel_w-1:0] alu_in_sel;
        logic                    en_reg;
        logic                    en_pc;

        modport drive (output hit, dest_reg, sour_reg, offset, sst, sci, rec,
                       alu_func, alu_in_sel, en_reg, en_pc);

        modport take (input hit, dest_reg, sour_reg, offset, sst, sci, rec,
                      alu_func, alu_in_sel, en_reg, en_pc);

endinterface

`default_nettype wire

//--- rtl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

        localparam int reg_addr_w   = 4;
        localparam int offset_w     = 8;
        localparam int alu_func_w   = 4;
        localparam int alu_in_sel_w = 4;
        localparam int code_w       = 2;     // sst, sci and rec

        typedef enum logic [2:0] {
                beat_fetch1 = 3'b000,
                beat_fetch2 = 3'b001,
                beat_exec   = 3'b011,
                beat_fetch0 = 3'b100
        } beat_t;

        // same 16 bits, register form or jump form
        typedef union packed {
                struct packed {
                        logic [7:0]            opcode;
                        logic [reg_addr_w-1:0] dest;
                        logic [reg_addr_w-1:0] sour;
                } reg_form;
                struct packed {
                        logic [7:0]          opcode;
                        logic [offset_w-1:0] offset;
                } jump_form;
        } instr_u;

        localparam logic [7:0] op_add  = 8'h00;
        localparam logic [7:0] op_sub  = 8'h01;
        localparam logic [7:0] op_and  = 8'h02;
        localparam logic [7:0] op_cmp  = 8'h03;
        localparam logic [7:0] op_xor  = 8'h04;
        localparam logic [7:0] op_test = 8'h05;
        localparam logic [7:0] op_or   = 8'h06;
        localparam logic [7:0] op_mov  = 8'h07;
        localparam logic [7:0] op_dec  = 8'h08;
        localparam logic [7:0] op_inc  = 8'h09;
        localparam logic [7:0] op_shl  = 8'h0a;
        localparam logic [7:0] op_shr  = 8'h0b;
        localparam logic [7:0] op_adc  = 8'h0c;
        localparam logic [7:0] op_sbb  = 8'h0d;
        localparam logic [7:0] op_not  = 8'h0e;
        localparam logic [7:0] op_div  = 8'h0f;
        localparam logic [7:0] op_mul  = 8'h10;
        localparam logic [7:0] op_rol  = 8'h11;
        localparam logic [7:0] op_ror  = 8'h12;
        localparam logic [7:0] op_sar  = 8'h13;
        localparam logic [7:0] op_rev  = 8'h14;     // last register-form opcode
        localparam logic [7:0] op_jmp  = 8'h40;
        localparam logic [7:0] op_js   = 8'h41;
        localparam logic [7:0] op_jns  = 8'h43;
        localparam logic [7:0] op_jc   = 8'h44;
        localparam logic [7:0] op_jnc  = 8'h45;
        localparam logic [7:0] op_jz   = 8'h46;
        localparam logic [7:0] op_jnz  = 8'h47;
        localparam logic [7:0] op_stc  = 8'h78;
        localparam logic [7:0] op_clc  = 8'h7a;

        localparam logic [code_w-1:0] sst_alu   = 2'b00;     // flags from alu
        localparam logic [code_w-1:0] sst_set   = 2'b01;
        localparam logic [code_w-1:0] sst_clear = 2'b10;
        localparam logic [code_w-1:0] sst_keep  = 2'b11;

        localparam logic [code_w-1:0] sci_zero = 2'b00;
        localparam logic [code_w-1:0] sci_one  = 2'b01;
        localparam logic [code_w-1:0] sci_flag = 2'b10;     // carry flag as cin

        localparam logic [code_w-1:0] rec_none = 2'b00;
        localparam logic [code_w-1:0] rec_ar   = 2'b01;
        localparam logic [code_w-1:0] rec_ir   = 2'b10;

        localparam logic [alu_func_w-1:0] fn_pass   = 4'b0000;     // a + b + cin
        localparam logic [alu_func_w-1:0] fn_sub    = 4'b0001;
        localparam logic [alu_func_w-1:0] fn_and    = 4'b0010;
        localparam logic [alu_func_w-1:0] fn_or     = 4'b0011;
        localparam logic [alu_func_w-1:0] fn_xor    = 4'b0100;
        localparam logic [alu_func_w-1:0] fn_shl    = 4'b0101;
        localparam logic [alu_func_w-1:0] fn_shr    = 4'b0110;
        localparam logic [alu_func_w-1:0] fn_not    = 4'b0111;
        localparam logic [alu_func_w-1:0] fn_div    = 4'b1000;
        localparam logic [alu_func_w-1:0] fn_mul    = 4'b1001;
        localparam logic [alu_func_w-1:0] fn_rol    = 4'b1010;
        localparam logic [alu_func_w-1:0] fn_ror    = 4'b1011;
        localparam logic [alu_func_w-1:0] fn_sar    = 4'b1100;
        localparam logic [alu_func_w-1:0] fn_bitrev = 4'b1101;

        localparam logic [alu_in_sel_w-1:0] in_reg    = 4'b0000;
        localparam logic [alu_in_sel_w-1:0] in_move   = 4'b0001;
        localparam logic [alu_in_sel_w-1:0] in_dest   = 4'b0010;
        localparam logic [alu_in_sel_w-1:0] in_offset = 4'b0011;
        localparam logic [alu_in_sel_w-1:0] in_pc     = 4'b0100;

        // register-form table, indexed by opcode: {alu_func, sst, sci, alu_in_sel}
        localparam int alu_ops     = 21;
        localparam int alu_entry_w = alu_func_w + 2 * code_w + alu_in_sel_w;
        localparam logic [alu_entry_w-1:0] alu_table [alu_ops] = '{
                {fn_pass,   sst_alu,  sci_zero, in_reg},      // add
                {fn_sub,    sst_alu,  sci_zero, in_reg},
                {fn_and,    sst_alu,  sci_zero, in_reg},
                {fn_sub,    sst_alu,  sci_zero, in_reg},      // cmp
                {fn_xor,    sst_alu,  sci_zero, in_reg},
                {fn_and,    sst_alu,  sci_zero, in_reg},      // test
                {fn_or,     sst_alu,  sci_zero, in_reg},
                {fn_pass,   sst_keep, sci_zero, in_move},     // mov
                {fn_sub,    sst_alu,  sci_one,  in_dest},     // dec
                {fn_pass,   sst_alu,  sci_one,  in_dest},     // inc
                {fn_shl,    sst_alu,  sci_zero, in_reg},
                {fn_shr,    sst_alu,  sci_zero, in_reg},
                {fn_pass,   sst_alu,  sci_flag, in_reg},      // adc
                {fn_sub,    sst_alu,  sci_flag, in_reg},      // sbb
                {fn_not,    sst_alu,  sci_flag, in_reg},
                {fn_div,    sst_alu,  sci_flag, in_reg},
                {fn_mul,    sst_alu,  sci_flag, in_reg},
                {fn_rol,    sst_alu,  sci_zero, in_reg},
                {fn_ror,    sst_alu,  sci_zero, in_reg},
                {fn_sar,    sst_alu,  sci_zero, in_reg},
                {fn_bitrev, sst_alu,  sci_zero, in_dest}
        };

endpackage

`default_nettype wire

//--- rtl/fetch_decode.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_decode (
        input  ctrl_pkg::beat_t timer,
        ctrl_if.drive           cw
);
        import ctrl_pkg::*;

        always_comb begin
                cw.hit        = 1'b0;
                cw.dest_reg   = '0;
                cw.sour_reg   = '0;
                cw.offset     = '0;
                cw.sst        = sst_keep;
                cw.sci        = sci_zero;
                cw.rec        = rec_none;
                cw.alu_func   = fn_pass;
                cw.alu_in_sel = in_reg;
                cw.en_reg     = 1'b0;
                cw.en_pc      = 1'b0;
                case (timer)
                        beat_fetch0: begin
                                cw.hit = 1'b1;     // bus cycle, nothing latched
                        end
                        beat_fetch1: begin
                                cw.hit        = 1'b1;
                                cw.sci        = sci_one;     // pc + 1
                                cw.alu_in_sel = in_pc;
                                cw.en_pc      = 1'b1;
                                cw.rec        = rec_ar;
                        end
                        beat_fetch2: begin
                                cw.hit = 1'b1;
                                cw.rec = rec_ir;     // load instruction register
                        end
                        default: begin
                        end
                endcase
        end

endmodule

`default_nettype wire

//--- tb/controller_checker.sv
`timescale 1ns/1ps
`default_nettype none

module controller_checker (
        input  logic        clk,
        input  logic        check_en,
        input  int          test_id,
        input  logic [31:0] expected,
        input  logic        finish,
        input  logic [3:0]  dest_reg,
        input  logic [3:0]  sour_reg,
        input  logic [7:0]  offset,
        input  logic [1:0]  sst,
        input  logic [1:0]  sci,
        input  logic [1:0]  rec,
        input  logic [3:0]  alu_func,
        input  logic [3:0]  alu_in_sel,
        input  logic        en_reg,
        input  logic        en_pc,
        output int          groups_ok,
        output int          groups_bad,
        output int          mismatches,
        output logic        reported
);
        logic        pend_en = 1'b0;
        int          pend_test;
        logic [31:0] pend_exp;
        int          cur_test = 0;
        int          cur_err = 0;
        int          n_ok = 0;
        int          n_bad = 0;
        int          n_err = 0;
        logic        done = 1'b0;

        assign groups_ok  = n_ok;
        assign groups_bad = n_bad;
        assign mismatches = n_err;
        assign reported   = done;

        task automatic check_field(input string name, input logic [7:0] got,
                                   input logic [7:0] want);
                if (got !== want) begin
                        $display("Mismatch at %0t: test %0d field %s got %0h expected %0h",
                                 $time, pend_test, name, got, want);
                        cur_err++;
                        n_err++;
                end
        endtask

        task automatic close_test();
                if (cur_test != 0) begin
                        if (cur_err == 0) n_ok++;
                        else n_bad++;
                        $display("group %0d done, %0d mismatches", cur_test, cur_err);
                end
                cur_err = 0;
        endtask

        // expectation is one edge behind the drive, matching the register stage
        always @(posedge clk) begin
                pend_en   <= check_en;
                pend_test <= test_id;
                pend_exp  <= expected;
        end

        always @(negedge clk) begin     // outputs settled here
                if (pend_en) begin
                        if (pend_test != cur_test) close_test();
                        cur_test = pend_test;
                        check_field("dest_reg", {4'h0, dest_reg}, {4'h0, pend_exp[31:28]});
                        check_field("sour_reg", {4'h0, sour_reg}, {4'h0, pend_exp[27:24]});
                        check_field("offset", offset, pend_exp[23:16]);
                        check_field("sst", {6'h0, sst}, {6'h0, pend_exp[15:14]});
                        check_field("sci", {6'h0, sci}, {6'h0, pend_exp[13:12]});
                        check_field("rec", {6'h0, rec}, {6'h0, pend_exp[11:10]});
                        check_field("alu_func", {4'h0, alu_func}, {4'h0, pend_exp[9:6]});
                        check_field("alu_in_sel", {4'h0, alu_in_sel}, {4'h0, pend_exp[5:2]});
                        check_field("en_reg", {7'h0, en_reg}, {7'h0, pend_exp[1]});
                        check_field("en_pc", {7'h0, en_pc}, {7'h0, pend_exp[0]});
                end
                if (finish && !done) begin
                        close_test();
                        done = 1'b1;
                end
        end

endmodule

`default_nettype wire

//--- tb/controller_sva.sv
`timescale 1ns/1ps
`default_nettype none

module controller_sva (
        input logic       clk,
        input logic       arst_n,
        input logic [2:0] hits,
        input logic [3:0] dest_reg,
        input logic [3:0] sour_reg,
        input logic [7:0] offset,
        input logic [1:0] sst,
        input logic [1:0] sci,
        input logic [1:0] rec,
        input logic [3:0] alu_func,
        input logic [3:0] alu_in_sel,
        input logic       en_reg,
        input logic       en_pc
);
        import ctrl_pkg::*;

        int fail_count = 0;

        // first edge in reset loads the reset word
        reset_values: assert property (@(posedge clk) (!arst_n && $past(!arst_n)) |->
                (sst == sst_keep && sci == sci_zero && rec == rec_none && dest_reg == '0
                 && sour_reg == '0 && offset == '0 && alu_func == fn_pass
                 && alu_in_sel == in_reg && !en_reg && !en_pc))
                else begin
                        fail_count++;
                        $error("control word differs from reset value during reset");
                end

        single_hit: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(hits))
                else begin
                        fail_count++;
                        $error("more than one decoder hit");
                end

        known_enables: assert property (@(posedge clk) arst_n |-> !$isunknown({en_reg, en_pc}))
                else begin
                        fail_count++;
                        $error("enable is unknown after reset");
                end

endmodule

`default_nettype wire

//--- tb/controller_trace.txt
# test timer instr c z s | dest sour offset sst sci rec alu_func alu_in_sel en_reg en_pc
# flag value 2 means random; timer, sst, sci, rec, en_reg, en_pc in binary, the rest in hex
1 010 0000 0 0 0 0 0 00 11 00 00 0 0 0 0
2 100 1234 0 0 0 0 0 00 11 00 00 0 0 0 0
2 000 1234 0 0 0 0 0 00 11 01 01 0 4 0 1
2 001 1234 0 0 0 0 0 00 11 00 10 0 0 0 0
3 011 0012 2 2 2 1 2 00 00 00 00 0 0 1 0
3 011 0123 2 2 2 2 3 00 00 00 00 1 0 1 0
3 011 0234 2 2 2 3 4 00 00 00 00 2 0 1 0
3 011 0345 2 2 2 4 5 00 00 00 00 1 0 0 0
3 011 0456 2 2 2 5 6 00 00 00 00 4 0 1 0
3 011 0567 2 2 2 6 7 00 00 00 00 2 0 0 0
3 011 0678 2 2 2 7 8 00 00 00 00 3 0 1 0
3 011 0789 2 2 2 8 9 00 11 00 00 0 1 1 0
3 011 089a 2 2 2 9 a 00 00 01 00 1 2 1 0
3 011 09ab 2 2 2 a b 00 00 01 00 0 2 1 0
3 011 0abc 2 2 2 b c 00 00 00 00 5 0 1 0
3 011 0bcd 2 2 2 c d 00 00 00 00 6 0 1 0
3 011 0cde 2 2 2 d e 00 00 10 00 0 0 1 0
3 011 0def 2 2 2 e f 00 00 10 00 1 0 1 0
3 011 0ef0 2 2 2 f 0 00 00 10 00 7 0 1 0
3 011 0f01 2 2 2 0 1 00 00 10 00 8 0 1 0
3 011 1012 2 2 2 1 2 00 00 10 00 9 0 1 0
3 011 1123 2 2 2 2 3 00 00 00 00 a 0 1 0
3 011 1234 2 2 2 3 4 00 00 00 00 b 0 1 0
3 011 1345 2 2 2 4 5 00 00 00 00 c 0 1 0
3 011 1456 2 2 2 5 6 00 00 00 00 d 2 1 0
4 011 4010 0 0 0 0 0 10 11 00 00 0 3 0 1
4 011 40a5 1 1 1 0 0 a5 11 00 00 0 3 0 1
4 011 4120 0 0 0 0 0 20 11 00 00 0 3 0 0
4 011 41b6 1 1 1 0 0 b6 11 00 00 0 3 0 1
4 011 4330 0 0 0 0 0 30 11 00 00 0 3 0 1
4 011 43c7 1 1 1 0 0 c7 11 00 00 0 3 0 0
4 011 4440 0 0 0 0 0 40 11 00 00 0 3 0 0
4 011 44d8 1 1 1 0 0 d8 11 00 00 0 3 0 1
4 011 4550 0 0 0 0 0 50 11 00 00 0 3 0 1
4 011 45e9 1 1 1 0 0 e9 11 00 00 0 3 0 0
4 011 4660 0 0 0 0 0 60 11 00 00 0 3 0 0
4 011 46fa 1 1 1 0 0 fa 11 00 00 0 3 0 1
4 011 4770 0 0 0 0 0 70 11 00 00 0 3 0 1
4 011 470b 1 1 1 0 0 0b 11 00 00 0 3 0 0
5 011 7833 2 2 2 0 0 33 01 00 00 0 0 0 0
5 011 7a44 2 2 2 0 0 44 10 00 00 0 0 0 0
6 011 2000 2 2 2 0 0 44 10 00 00 0 0 0 0
6 010 0012 2 2 2 0 0 44 10 00 00 0 0 0 0

//--- tb/tb_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_controller;
        logic        clk;
        logic        arst_n;
        logic [2:0]  timer;
        logic [15:0] instruction;
        logic        c, z, s;
        logic [3:0]  dest_reg, sour_reg, alu_func, alu_in_sel;
        logic [7:0]  offset;
        logic [1:0]  sst, sci, rec;
        logic        en_reg, en_pc;
        logic        check_en, finish, reported;
        int          test_id;
        logic [31:0] expected;
        int          groups_ok, groups_bad, mismatches;

        controller controller_inst (.*);

        controller_checker checker_inst (.*);

        bind control_register controller_sva controller_sva_inst (
                .clk (clk), .arst_n (arst_n),
                .hits ({fetch_cw.hit, alu_cw.hit, branch_cw.hit}),
                .dest_reg (dest_reg), .sour_reg (sour_reg), .offset (offset),
                .sst (sst), .sci (sci), .rec (rec), .alu_func (alu_func),
                .alu_in_sel (alu_in_sel), .en_reg (en_reg), .en_pc (en_pc)
        );

        function automatic logic flag_value(input int code);
                if (code == 2) return 1'($urandom % 2);     // don't-care flag
                return code[0];
        endfunction

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        initial begin
                int          fd, n, cycles, tnum, fc, fz, fs;
                int          assert_fails;
                string       line;
                logic [2:0]  t;
                logic [15:0] ins;
                logic [3:0]  ed, es, ef, esel;
                logic [7:0]  eo;
                logic [1:0]  esst, esci, erec;
                logic        eer, eep;
                bit          bad_run;
                void'($urandom(30));
                arst_n = 1'b0;
                timer = 3'b010;
                instruction = '0;
                c = 1'b0;
                z = 1'b0;
                s = 1'b0;
                check_en = 1'b0;
                finish = 1'b0;
                test_id = 0;
                expected = '0;
                bad_run = 1'b0;
                repeat (8) @(posedge clk);
                arst_n <= 1'b1;
                cycles = 0;
                while (arst_n !== 1'b1 && cycles < 10) begin
                        @(posedge clk);
                        cycles++;
                end
                if (arst_n !== 1'b1) bad_run = 1'b1;
                fd = $fopen("tb/controller_trace.txt", "r");
                if (fd == 0) begin
                        $display("could not open the trace file");
                        bad_run = 1'b1;
                end else begin
                        cycles = 0;
                        while (!$feof(fd) && cycles < 200) begin
                                n = $fgets(line, fd);
                                cycles++;
                                if (n > 1 && line.getc(0) != "#") begin
                                        n = $sscanf(line,
                                                "%d %b %h %d %d %d %h %h %h %b %b %b %h %h %b %b",
                                                tnum, t, ins, fc, fz, fs, ed, es, eo,
                                                esst, esci, erec, ef, esel, eer, eep);
                                        if (n == 16) begin
                                                @(posedge clk);
                                                timer       <= t;
                                                instruction <= ins;
                                                c           <= flag_value(fc);
                                                z           <= flag_value(fz);
                                                s           <= flag_value(fs);
                                                test_id     <= tnum;
                                                expected    <= {ed, es, eo, esst, esci, erec,
                                                                ef, esel, eer, eep};
                                                check_en    <= 1'b1;
                                        end
                                end
                        end
                        if (!$feof(fd)) begin
                                $display("trace reading did not reach end of file in time");
                                bad_run = 1'b1;
                        end
                        $fclose(fd);
                end
                @(posedge clk);
                check_en <= 1'b0;
                finish   <= 1'b1;
                cycles = 0;
                while (!reported && cycles < 10) begin
                        @(posedge clk);
                        cycles++;
                end
                if (!reported) begin
                        $display("checker did not report its last group in time");
                        bad_run = 1'b1;
                end
                assert_fails =
                        controller_inst.control_register_inst.controller_sva_inst.fail_count;
                $display("groups ok %0d, groups bad %0d, mismatches %0d, assertion failures %0d",
                         groups_ok, groups_bad, mismatches, assert_fails);
                if (!bad_run && groups_bad == 0 && mismatches == 0 && assert_fails == 0
                    && groups_ok > 0) begin
                        $display("test passed");
                end else begin
                        $display("test failed");
                end
                $finish;
        end

endmodule

`default_nettype wire
